// ==== include/dino_defines.svh ====
// ##############################
// Screen timing, object geometry, colours,
// bus register map and motion step period
// ##############################
`ifndef DINO_DEFINES_SVH
`define DINO_DEFINES_SVH

// Horizontal timing in clk cycles
`define H_ACTIVE 1280
`define H_FRONT 32
`define H_SYNC 192
`define H_BACK 96
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// Vertical timing in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

`define COORD_W 11
`define LINE_W 10

// Object geometry
`define OBJ_SIZE 32
`define GROUP_W 64
`define GROUND_Y 248
`define PTR_Y 200
`define DINO_START_X 100
`define START_CACTUS_X 1200
`define START_GROUP_X 1600
`define START_LAVA_X 1800
`define START_PTR_X 1400

`define PASSES_PER_SPEEDUP 12
`define LFSR_SEED 6'b101011

// Score and background layout
`define N_DIGITS 5
`define SCORE_X 120
`define SCORE_Y 10
`define HORIZON_Y 280
`define STRIPE_Y 300
`define REPLAY_X 560
`define REPLAY_Y 200
`define REPLAY_W 160

// Colours as 24-bit RGB
`define COLOR_SKY 24'h87CEEB
`define COLOR_GROUND 24'h8B4513
`define COLOR_STRIPE 24'h64280A
`define COLOR_LINE 24'h000000
`define COLOR_DINO 24'h505050
`define COLOR_CACTUS 24'h228B22
`define COLOR_GROUP 24'h006400
`define COLOR_LAVA 24'hFF4500
`define COLOR_PTR 24'h6A3D9A
`define COLOR_REPLAY 24'hFF0000
`define COLOR_DIGIT 24'h000000

// Bus map, write side
`define ADDR_DINO_X 0
`define ADDR_DINO_Y 1
`define ADDR_LAVA_X 17
`define ADDR_LAVA_Y 18
`define ADDR_REPLAY 19
// Bus map, read side
`define ADDR_SCORE 0
`define ADDR_STATUS 1

`define DEFAULT_STEP_CYCLES 2000000

`endif

// ==== verilog/dino_pkg.sv ====
// ##############################
// Shared structs and the bus word union
// ##############################
`include "dino_defines.svh"

package dino_pkg;

    typedef struct packed {
        logic [`COORD_W-1:0] hcount;
        logic [`LINE_W-1:0]  vcount;
    } scan_pos_t;

    typedef struct packed {
        logic vga_clk;
        logic hs;
        logic vs;
        logic blank_n;
        logic sync_n;
    } vga_sync_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    // Positions read by both the collision test and the renderer
    typedef struct packed {
        logic [`COORD_W-1:0] dino_x;
        logic [`COORD_W-1:0] dino_y;
        logic [`COORD_W-1:0] cactus_x;
        logic [`COORD_W-1:0] group_x;
        logic [`COORD_W-1:0] lava_x;
        logic [`COORD_W-1:0] lava_y;
        logic [`COORD_W-1:0] ptr_x;
    } world_t;

    typedef struct packed {
        logic [31-`COORD_W:0] pad;
        logic [`COORD_W-1:0]  value;
    } coord_word_t;

    typedef struct packed {
        logic [30:0] pad;
        logic        flag;
    } flag_word_t;

    // Write word seen as a coordinate or as a command bit
    typedef union packed {
        coord_word_t coord_view;
        flag_word_t  flag_view;
    } bus_word_u;

    // BCD digits, index N_DIGITS-1 is the most significant
    typedef logic [`N_DIGITS-1:0][3:0] score_t;

endpackage

// ==== verilog/vga_timing.sv ====
// ##############################
// Raster counters with sync and blank decode
// ##############################
`timescale 1ns/1ps
`include "dino_defines.svh"

module vga_timing (
    input  logic                clk,
    input  logic                reset,
    output dino_pkg::scan_pos_t scan,
    output dino_pkg::vga_sync_t sync
);

    logic [`COORD_W-1:0] hcount;
    logic [`LINE_W-1:0]  vcount;
    logic                end_of_line;
    logic                end_of_frame;

    assign end_of_line  = (hcount == `COORD_W'(`H_TOTAL - 1));
    assign end_of_frame = (vcount == `LINE_W'(`V_TOTAL - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else if (end_of_line) begin
            hcount <= '0;
            vcount <= end_of_frame ? '0 : vcount + 1'b1;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    assign scan = '{hcount: hcount, vcount: vcount};

    assign sync = '{
        vga_clk: hcount[0],
        hs:      !((hcount >= `H_ACTIVE + `H_FRONT) &&
                   (hcount < `H_ACTIVE + `H_FRONT + `H_SYNC)),
        vs:      !((vcount >= `V_ACTIVE + `V_FRONT) &&
                   (vcount < `V_ACTIVE + `V_FRONT + `V_SYNC)),
        blank_n: (hcount < `H_ACTIVE) && (vcount < `V_ACTIVE),
        sync_n:  1'b0
    };

    a_hcount_range: assert property (@(posedge clk) disable iff (reset)
        hcount < `COORD_W'(`H_TOTAL));

endmodule

// ==== verilog/cpu_regs.sv ====
// ##############################
// Bus register map and read port
// ##############################
`timescale 1ns/1ps
`include "dino_defines.svh"

module cpu_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic                chipselect,
    input  logic                write,
    input  logic                read,
    input  logic [8:0]          address,
    input  dino_pkg::bus_word_u writedata,
    input  dino_pkg::score_t    score,
    input  logic                game_over,
    input  logic [`COORD_W-1:0] speed,
    output logic [`COORD_W-1:0] dino_x,
    output logic [`COORD_W-1:0] dino_y,
    output logic                lava_set_x,
    output logic                lava_set_y,
    output logic                replay,
    output logic [`COORD_W-1:0] lava_value,
    output logic [31:0]         readdata
);

    logic wr;

    assign wr = chipselect && write;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dino_x <= `COORD_W'(`DINO_START_X);
            dino_y <= `COORD_W'(`GROUND_Y);
        end else if (wr) begin
            if (address == 9'(`ADDR_DINO_X))
                dino_x <= writedata.coord_view.value;
            if (address == 9'(`ADDR_DINO_Y))
                dino_y <= writedata.coord_view.value;
        end
    end

    // Lava loads and replay act on the strobe edge itself
    assign lava_set_x = wr && (address == 9'(`ADDR_LAVA_X));
    assign lava_set_y = wr && (address == 9'(`ADDR_LAVA_Y));
    assign replay     = wr && (address == 9'(`ADDR_REPLAY)) && writedata.flag_view.flag;
    assign lava_value = writedata.coord_view.value;

    // Read data holds until the next read strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readdata <= '0;
        end else if (chipselect && read) begin
            case (address)
                9'(`ADDR_SCORE):  readdata <= {12'd0, score};
                9'(`ADDR_STATUS): readdata <= {{(16 - `COORD_W){1'b0}}, speed, 15'd0, game_over};
                default:          readdata <= '0;
            endcase
        end
    end

    a_pulses_exclusive: assert property (@(posedge clk) disable iff (reset)
        $onehot0({lava_set_x, lava_set_y, replay}));

endmodule

// ==== verilog/obstacle_field.sv ====
// ##############################
// Step timer, LFSR and obstacle scrolling
// ##############################
`timescale 1ns/1ps
`include "dino_defines.svh"

module obstacle_field #(
    parameter int step_cycles = `DEFAULT_STEP_CYCLES
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                game_over,
    input  logic                replay,
    input  logic                lava_set_x,
    input  logic                lava_set_y,
    input  logic [`COORD_W-1:0] lava_value,
    output dino_pkg::world_t    obstacles,
    output logic                step,
    output logic [`COORD_W-1:0] speed
);

    localparam int TIMER_W = $clog2(step_cycles + 1);

    logic [TIMER_W-1:0]  timer;
    logic [5:0]          lfsr;
    logic [4:0]          passes;
    logic [`COORD_W-1:0] cactus_x;
    logic [`COORD_W-1:0] group_x;
    logic [`COORD_W-1:0] lava_x;
    logic [`COORD_W-1:0] lava_y;
    logic [`COORD_W-1:0] ptr_x;
    logic                restart;
    logic                any_wrap;

    // Move left, or wrap past the right edge once the speed would cross zero
    function automatic logic [`COORD_W-1:0] advance(
        input logic [`COORD_W-1:0] x,
        input logic [`COORD_W-1:0] offset,
        input logic [`COORD_W-1:0] spd
    );
        return (x <= spd) ? `COORD_W'(`H_ACTIVE) + offset : x - spd;
    endfunction

    assign restart  = replay && game_over;
    assign step     = !game_over && (timer == TIMER_W'(step_cycles - 1));
    assign any_wrap = (cactus_x <= speed) || (group_x <= speed) ||
                      (lava_x <= speed) || (ptr_x <= speed);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            timer    <= '0;
            lfsr     <= `LFSR_SEED;
            passes   <= '0;
            speed    <= `COORD_W'(1);
            cactus_x <= `COORD_W'(`START_CACTUS_X);
            group_x  <= `COORD_W'(`START_GROUP_X);
            lava_x   <= `COORD_W'(`START_LAVA_X);
            lava_y   <= `COORD_W'(`GROUND_Y);
            ptr_x    <= `COORD_W'(`START_PTR_X);
        end else if (restart) begin
            timer    <= '0;
            passes   <= '0;
            speed    <= `COORD_W'(1);
            cactus_x <= `COORD_W'(`START_CACTUS_X);
            group_x  <= `COORD_W'(`START_GROUP_X);
            lava_x   <= `COORD_W'(`START_LAVA_X);
            lava_y   <= `COORD_W'(`GROUND_Y);
            ptr_x    <= `COORD_W'(`START_PTR_X);
        end else begin
            if (step)
                timer <= '0;
            else if (!game_over)
                timer <= timer + 1'b1;

            if (step) begin
                // x^6 + x^5 + 1
                lfsr     <= {lfsr[4:0], lfsr[5] ^ lfsr[4]};
                cactus_x <= advance(cactus_x, {1'b0, lfsr, 4'd0}, speed);
                group_x  <= advance(group_x, {1'b0, ~lfsr, 4'd0}, speed);
                lava_x   <= advance(lava_x, {1'b0, lfsr[3:0], 6'd0}, speed);
                ptr_x    <= advance(ptr_x, {1'b0, lfsr[5:2], 6'd0}, speed);
                if (passes > 5'(`PASSES_PER_SPEEDUP)) begin
                    speed  <= speed + 1'b1;
                    passes <= '0;
                end else if (any_wrap) begin
                    passes <= passes + 1'b1;
                end
            end

            // Bus loads win over a step on the same edge
            if (lava_set_x)
                lava_x <= lava_value;
            if (lava_set_y)
                lava_y <= lava_value;
        end
    end

    assign obstacles = '{
        dino_x:   '0,
        dino_y:   '0,
        cactus_x: cactus_x,
        group_x:  group_x,
        lava_x:   lava_x,
        lava_y:   lava_y,
        ptr_x:    ptr_x
    };

    a_speed_nonzero: assert property (@(posedge clk) disable iff (reset) speed != '0);

endmodule

// ==== verilog/game_state.sv ====
// ##############################
// Collision, game-over latch and BCD score
// ##############################
`timescale 1ns/1ps
`include "dino_defines.svh"

module game_state (
    input  logic             clk,
    input  logic             reset,
    input  logic             step,
    input  logic             replay,
    input  dino_pkg::world_t world,
    output logic             game_over,
    output dino_pkg::score_t score
);

    localparam logic [`COORD_W:0] OBJ_W   = `OBJ_SIZE;
    localparam logic [`COORD_W:0] GROUP_W = `GROUP_W;

    logic hit;

    // Strict overlap of the 32x32 dino box with a box of width bw
    function automatic logic overlap(
        input logic [`COORD_W-1:0] ax,
        input logic [`COORD_W-1:0] ay,
        input logic [`COORD_W-1:0] bx,
        input logic [`COORD_W-1:0] by,
        input logic [`COORD_W:0]   bw
    );
        return ({1'b0, ax} < {1'b0, bx} + bw) && ({1'b0, ax} + OBJ_W > {1'b0, bx}) &&
               ({1'b0, ay} < {1'b0, by} + OBJ_W) && ({1'b0, ay} + OBJ_W > {1'b0, by});
    endfunction

    function automatic dino_pkg::score_t bcd_increment(input dino_pkg::score_t s);
        dino_pkg::score_t n;
        logic             carry;
        n     = s;
        carry = 1'b1;
        for (int i = 0; i < `N_DIGITS; i++) begin
            if (carry) begin
                if (s[i] == 4'd9) begin
                    n[i] = 4'd0;
                end else begin
                    n[i]  = s[i] + 4'd1;
                    carry = 1'b0;
                end
            end
        end
        return n;
    endfunction

    function automatic logic digits_valid(input dino_pkg::score_t s);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < `N_DIGITS; i++)
            ok = ok && (s[i] <= 4'd9);
        return ok;
    endfunction

    // Ground obstacles share the lava row
    assign hit = overlap(world.dino_x, world.dino_y, world.cactus_x, world.lava_y, OBJ_W) ||
                 overlap(world.dino_x, world.dino_y, world.group_x, world.lava_y, GROUP_W) ||
                 overlap(world.dino_x, world.dino_y, world.lava_x, world.lava_y, OBJ_W) ||
                 overlap(world.dino_x, world.dino_y, world.ptr_x, `COORD_W'(`PTR_Y), OBJ_W);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            game_over <= 1'b0;
            score     <= '0;
        end else if (replay && game_over) begin
            game_over <= 1'b0;
            score     <= '0;
        end else begin
            if (hit)
                game_over <= 1'b1;
            if (step)
                score <= bcd_increment(score);
        end
    end

    a_score_bcd: assert property (@(posedge clk) disable iff (reset) digits_valid(score));

endmodule

// ==== verilog/scene_renderer.sv ====
// ##############################
// Pixel colour from background, boxes and score
// ##############################
`timescale 1ns/1ps
`include "dino_defines.svh"

module scene_renderer (
    input  logic                clk,
    input  logic                reset,
    input  logic                game_over,
    input  dino_pkg::scan_pos_t scan,
    input  dino_pkg::world_t    world,
    input  dino_pkg::score_t    score,
    output dino_pkg::pixel_t    pixel
);

    localparam logic [`COORD_W:0] OBJ_W    = `OBJ_SIZE;
    localparam logic [`COORD_W:0] GROUP_W  = `GROUP_W;
    localparam logic [`COORD_W:0] BANNER_W = `REPLAY_W;

    // 8x8 digit glyphs, bit 7 is the leftmost pixel
    localparam logic [7:0] FONT [10][8] = '{
        '{8'h3C, 8'h42, 8'h46, 8'h4A, 8'h52, 8'h62, 8'h3C, 8'h00},
        '{8'h08, 8'h18, 8'h28, 8'h08, 8'h08, 8'h08, 8'h3E, 8'h00},
        '{8'h3C, 8'h42, 8'h02, 8'h0C, 8'h30, 8'h40, 8'h7E, 8'h00},
        '{8'h7E, 8'h04, 8'h08, 8'h1C, 8'h02, 8'h42, 8'h3C, 8'h00},
        '{8'h04, 8'h0C, 8'h14, 8'h24, 8'h7E, 8'h04, 8'h04, 8'h00},
        '{8'h7E, 8'h40, 8'h7C, 8'h02, 8'h02, 8'h42, 8'h3C, 8'h00},
        '{8'h1C, 8'h20, 8'h40, 8'h7C, 8'h42, 8'h42, 8'h3C, 8'h00},
        '{8'h7E, 8'h02, 8'h04, 8'h08, 8'h10, 8'h10, 8'h10, 8'h00},
        '{8'h3C, 8'h42, 8'h42, 8'h3C, 8'h42, 8'h42, 8'h3C, 8'h00},
        '{8'h3C, 8'h42, 8'h42, 8'h3E, 8'h02, 8'h04, 8'h38, 8'h00}
    };

    logic [`COORD_W-1:0] h;
    logic [`COORD_W-1:0] v;
    logic [`COORD_W-1:0] rx;
    logic [2:0]          row;
    logic [3:0]          digit;
    logic                in_score;
    logic                font_on;
    dino_pkg::pixel_t    colour;

    // All boxes are OBJ_SIZE tall
    function automatic logic in_box(
        input logic [`COORD_W-1:0] px,
        input logic [`COORD_W-1:0] py,
        input logic [`COORD_W-1:0] bx,
        input logic [`COORD_W-1:0] by,
        input logic [`COORD_W:0]   bw
    );
        return (px >= bx) && ({1'b0, px} < {1'b0, bx} + bw) &&
               (py >= by) && ({1'b0, py} < {1'b0, by} + OBJ_W);
    endfunction

    always_comb begin
        h        = scan.hcount;
        v        = {1'b0, scan.vcount};
        rx       = h - `COORD_W'(`SCORE_X);
        row      = 3'(v - `COORD_W'(`SCORE_Y));
        in_score = (v >= `SCORE_Y) && (v < `SCORE_Y + 8) &&
                   (h >= `SCORE_X) && (h < `SCORE_X + `N_DIGITS * 8);
        digit    = 4'd0;
        font_on  = 1'b0;
        if (in_score) begin
            // Leftmost glyph shows the most significant digit
            digit   = score[`N_DIGITS - 1 - int'(rx[5:3])];
            font_on = FONT[digit][row][3'd7 - rx[2:0]];
        end

        if (v < `HORIZON_Y)
            colour = dino_pkg::pixel_t'(`COLOR_SKY);
        else if (v == `HORIZON_Y)
            colour = dino_pkg::pixel_t'(`COLOR_LINE);
        else if (v > `STRIPE_Y)
            colour = dino_pkg::pixel_t'(`COLOR_STRIPE);
        else
            colour = dino_pkg::pixel_t'(`COLOR_GROUND);

        if (game_over) begin
            if (in_box(h, v, `COORD_W'(`REPLAY_X), `COORD_W'(`REPLAY_Y), BANNER_W))
                colour = dino_pkg::pixel_t'(`COLOR_REPLAY);
        end else begin
            if (in_box(h, v, world.dino_x, world.dino_y, OBJ_W))
                colour = dino_pkg::pixel_t'(`COLOR_DINO);
            if (in_box(h, v, world.cactus_x, world.lava_y, OBJ_W))
                colour = dino_pkg::pixel_t'(`COLOR_CACTUS);
            if (in_box(h, v, world.group_x, world.lava_y, GROUP_W))
                colour = dino_pkg::pixel_t'(`COLOR_GROUP);
            if (in_box(h, v, world.lava_x, world.lava_y, OBJ_W))
                colour = dino_pkg::pixel_t'(`COLOR_LAVA);
            if (in_box(h, v, world.ptr_x, `COORD_W'(`PTR_Y), OBJ_W))
                colour = dino_pkg::pixel_t'(`COLOR_PTR);
            if (font_on)
                colour = dino_pkg::pixel_t'(`COLOR_DIGIT);
        end
    end

    // One cycle behind the scan position
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            pixel <= '0;
        else
            pixel <= colour;
    end

endmodule

// ==== verilog/dino_top.sv ====
// ##############################
// Game core top level
// ##############################
`timescale 1ns/1ps
`include "dino_defines.svh"

module dino_top #(
    parameter int step_cycles = `DEFAULT_STEP_CYCLES
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                chipselect,
    input  logic                write,
    input  logic                read,
    input  logic [8:0]          address,
    input  dino_pkg::bus_word_u writedata,
    output logic [31:0]         readdata,
    output logic [7:0]          vga_r,
    output logic [7:0]          vga_g,
    output logic [7:0]          vga_b,
    output logic                vga_clk,
    output logic                vga_hs,
    output logic                vga_vs,
    output logic                vga_blank_n,
    output logic                vga_sync_n
);

    dino_pkg::scan_pos_t scan;
    dino_pkg::vga_sync_t sync;
    dino_pkg::pixel_t    pixel;
    dino_pkg::world_t    obstacles;
    dino_pkg::world_t    world;
    dino_pkg::score_t    score;
    logic [`COORD_W-1:0] dino_x;
    logic [`COORD_W-1:0] dino_y;
    logic [`COORD_W-1:0] lava_value;
    logic [`COORD_W-1:0] speed;
    logic                lava_set_x;
    logic                lava_set_y;
    logic                replay;
    logic                step;
    logic                game_over;

    vga_timing u_timing (.clk(clk), .reset(reset), .scan(scan), .sync(sync));

    cpu_regs u_regs (
        .clk(clk), .reset(reset), .chipselect(chipselect), .write(write), .read(read),
        .address(address), .writedata(writedata), .score(score), .game_over(game_over),
        .speed(speed), .dino_x(dino_x), .dino_y(dino_y), .lava_set_x(lava_set_x),
        .lava_set_y(lava_set_y), .replay(replay), .lava_value(lava_value),
        .readdata(readdata)
    );

    obstacle_field #(.step_cycles(step_cycles)) u_field (
        .clk(clk), .reset(reset), .game_over(game_over), .replay(replay),
        .lava_set_x(lava_set_x), .lava_set_y(lava_set_y), .lava_value(lava_value),
        .obstacles(obstacles), .step(step), .speed(speed)
    );

    // Dino position comes from the bus registers
    always_comb begin
        world        = obstacles;
        world.dino_x = dino_x;
        world.dino_y = dino_y;
    end

    game_state u_state (
        .clk(clk), .reset(reset), .step(step), .replay(replay), .world(world),
        .game_over(game_over), .score(score)
    );

    scene_renderer u_render (
        .clk(clk), .reset(reset), .game_over(game_over), .scan(scan), .world(world),
        .score(score), .pixel(pixel)
    );

    assign vga_r       = pixel.r;
    assign vga_g       = pixel.g;
    assign vga_b       = pixel.b;
    assign vga_clk     = sync.vga_clk;
    assign vga_hs      = sync.hs;
    assign vga_vs      = sync.vs;
    assign vga_blank_n = sync.blank_n;
    assign vga_sync_n  = sync.sync_n;

endmodule

// ==== bench/dino_tb.sv ====
// ##############################
// Game core testbench, steps read from a data file
// ##############################
`timescale 1ns/1ps
`include "dino_defines.svh"

module dino_tb;

    localparam int STEP_CYCLES = 50;
    localparam int MAX_ROWS    = 64;
    localparam int MARGIN      = 200;

    // Row operations in the data file
    localparam int OP_END   = 0;
    localparam int OP_WRITE = 1;
    localparam int OP_READ  = 2;
    localparam int OP_WAIT  = 3;
    localparam int OP_HSYNC = 4;

    logic                clk;
    logic                reset;
    logic                chipselect;
    logic                write;
    logic                read;
    logic [8:0]          address;
    dino_pkg::bus_word_u writedata;
    logic [31:0]         readdata;
    logic [7:0]          vga_r;
    logic [7:0]          vga_g;
    logic [7:0]          vga_b;
    logic                vga_clk;
    logic                vga_hs;
    logic                vga_vs;
    logic                vga_blank_n;
    logic                vga_sync_n;

    logic [31:0] tests [MAX_ROWS * 4];
    int          errors;
    int          checks;
    int          cycles;
    int          limit;

    dino_top #(.step_cycles(STEP_CYCLES)) DUT (
        .clk(clk), .reset(reset), .chipselect(chipselect), .write(write), .read(read),
        .address(address), .writedata(writedata), .readdata(readdata),
        .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_clk(vga_clk),
        .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank_n(vga_blank_n),
        .vga_sync_n(vga_sync_n)
    );

    always #5 clk = ~clk;

    // Watchdog on the total cycle count
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Checks run: %0d, errors: %0d", checks, errors + 1);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0d ns: %s, got %h, expected %h", $time, what, actual,
                     expected);
        end
    endtask

    task automatic bus_write(input logic [8:0] addr, input logic [31:0] data);
        @(posedge clk);
        chipselect <= 1'b1;
        write      <= 1'b1;
        address    <= addr;
        writedata  <= dino_pkg::bus_word_u'(data);
        @(posedge clk);
        chipselect <= 1'b0;
        write      <= 1'b0;
    endtask

    // Read data is registered, so look at it half a cycle after the capture edge
    task automatic read_and_compare(input logic [8:0] addr, input logic [31:0] expected);
        @(posedge clk);
        chipselect <= 1'b1;
        read       <= 1'b1;
        address    <= addr;
        @(posedge clk);
        chipselect <= 1'b0;
        read       <= 1'b0;
        @(negedge clk);
        check_value(readdata, expected, $sformatf("read of address %0d", addr));
    endtask

    // One raster line, starting at a falling edge of hs
    // The dino sits at the top left by now, so the line shows sky and one dino box
    task automatic measure_line(input logic [31:0] period_exp, input logic [31:0] low_exp);
        int          low_count;
        int          period;
        int          blank_count;
        int          clk_toggles;
        int          vs_low;
        int          sync_n_high;
        int          sky_count;
        int          dino_count;
        logic        last_clk;
        logic        last_hs;
        logic [23:0] colour;
        low_count   = 0;
        period      = 0;
        blank_count = 0;
        clk_toggles = 0;
        vs_low      = 0;
        sync_n_high = 0;
        sky_count   = 0;
        dino_count  = 0;
        @(negedge clk);
        while (vga_hs !== 1'b1)
            @(negedge clk);
        while (vga_hs !== 1'b0)
            @(negedge clk);
        // Now on the first low cycle after a falling edge
        last_clk = ~vga_clk;
        last_hs  = 1'b0;
        while (!(last_hs === 1'b1 && vga_hs === 1'b0)) begin
            colour = {vga_r, vga_g, vga_b};
            if (vga_hs === 1'b0)
                low_count++;
            if (vga_blank_n === 1'b1)
                blank_count++;
            if (vga_clk !== last_clk)
                clk_toggles++;
            if (vga_vs !== 1'b1)
                vs_low++;
            if (vga_sync_n !== 1'b0)
                sync_n_high++;
            if (colour === `COLOR_SKY)
                sky_count++;
            else if (colour === `COLOR_DINO)
                dino_count++;
            last_clk = vga_clk;
            last_hs  = vga_hs;
            period++;
            @(negedge clk);
        end
        check_value(low_count, low_exp, "hs low width");
        check_value(period, period_exp, "hs falling edge spacing");
        check_value(clk_toggles, period_exp, "vga_clk toggles per line");
        check_value(blank_count, `H_ACTIVE, "blank_n high cycles per line");
        check_value(vs_low, 0, "vs low cycles on an active line");
        check_value(sync_n_high, 0, "sync_n high cycles");
        check_value(sky_count, period_exp - `OBJ_SIZE, "sky pixels per line");
        check_value(dino_count, `OBJ_SIZE, "dino pixels per line");
    endtask

    initial begin
        int row;
        int i;
        clk        = 1'b0;
        reset      = 1'b1;
        chipselect = 1'b0;
        write      = 1'b0;
        read       = 1'b0;
        address    = '0;
        writedata  = '0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        for (i = 0; i < MAX_ROWS * 4; i++)
            tests[i] = '0;
        $readmemh("bench/game_tests.mem", tests);

        // Limit from the wait rows plus a few raster lines
        limit = 4 * `H_TOTAL + MARGIN;
        for (i = 0; i < MAX_ROWS; i++)
            if (tests[4 * i] == OP_WAIT)
                limit += int'(tests[4 * i + 2]);

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        row = 0;
        while (row < MAX_ROWS && tests[4 * row] != OP_END) begin
            case (tests[4 * row])
                OP_WRITE: bus_write(tests[4 * row + 1][8:0], tests[4 * row + 2]);
                OP_READ:  read_and_compare(tests[4 * row + 1][8:0], tests[4 * row + 3]);
                OP_WAIT:  repeat (int'(tests[4 * row + 2])) @(posedge clk);
                OP_HSYNC: measure_line(tests[4 * row + 2], tests[4 * row + 3]);
                default: begin
                    errors++;
                    $display("Unknown operation %0h in row %0d of the test file",
                             tests[4 * row], row);
                end
            endcase
            row++;
        end

        @(posedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== bench/game_tests.mem ====
// Columns: operation, address, data, expected value (all hex)
// Operations: 1 write, 2 read and compare, 3 wait data cycles, 4 hs period and low width
02 000 00000000 00000000 // score after reset
02 001 00000000 00010000 // status, speed 1 and no game over
03 000 00000014 00000000 // settle
01 001 00000000 00000000 // dino y to 0
03 000 000001F4 00000000 // ten step periods
02 000 00000000 00000010 // score 10
01 011 00000064 00000000 // lava x onto the dino
01 012 00000000 00000000 // lava y onto the dino
03 000 00000002 00000000
02 001 00000000 00010001 // game over set
03 000 000000FA 00000000 // five step periods
02 000 00000000 00000010 // score frozen
01 013 00000001 00000000 // replay
02 001 00000000 00010000 // game over clear, speed 1
02 000 00000000 00000000 // score cleared
04 000 00000640 000000C0 // line of 1600, sync low 192
00 000 00000000 00000000

// ==== project.f ====
+incdir+include
verilog/dino_pkg.sv
verilog/vga_timing.sv
verilog/cpu_regs.sv
verilog/obstacle_field.sv
verilog/game_state.sv
verilog/scene_renderer.sv
verilog/dino_top.sv
bench/dino_tb.sv

// ==== Makefile ====
SOURCES := $(wildcard include/*.svh verilog/*.sv bench/*.sv)

obj_dir/Vdino_tb: project.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module dino_tb -f project.f

run: obj_dir/Vdino_tb bench/game_tests.mem
	obj_dir/Vdino_tb | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
